/* rtl/pio_pkg.sv */
/*
 * Register bus (PIO) types for the topic storage block.
 * Addresses are quad-word addresses. The bank select bit and the entry
 * bits are picked out by the modules that decode them.
 * Import with pio_pkg::* where a PIO port is declared.
 */
`default_nettype none

package pio_pkg;

	// quad-word address on the register bus
	typedef logic [15:0] pio_addr_t;

	// one register bus data word, also the width of a hash-table bucket
	typedef logic [31:0] pio_data_t;

endpackage

`default_nettype wire

/* rtl/topic_mem_pkg.sv */
/*
 * Entry types of the topic tables.
 * bucket_t is one hash-table bucket and matches pio_data_t bit for bit,
 * so PIO data maps onto a bucket with no packing.
 * The key and expiration-time types size the two value tables.
 */
`default_nettype none

package topic_mem_pkg;

	// one hash-table bucket
	typedef logic [31:0] bucket_t;

	// stored topic key, one per topic id
	typedef logic [63:0] topic_key_t;

	// expiration time written by the verification result strobe
	typedef logic [31:0] exp_time_t;

endpackage

`default_nettype wire

/* rtl/ram_1r1w.sv */
/*
 * Single-clock RAM with one write port and one read port.
 * Read data is registered and shows up one cycle after raddr.
 * A read and a write to the same entry in one cycle return the old data.
 */
`timescale 1ns/10ps
`default_nettype none

module ram_1r1w #(
	parameter int WIDTH      = 32,
	parameter int ADDR_NBITS = 6
) (
	input  logic                  clk,
	input  logic                  wr,
	input  logic [ADDR_NBITS-1:0] waddr,
	input  logic [WIDTH-1:0]      din,
	input  logic [ADDR_NBITS-1:0] raddr,
	output logic [WIDTH-1:0]      dout
);

	logic [WIDTH-1:0] mem [2**ADDR_NBITS];

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		dout <= mem[raddr];	// registered read
	end

endmodule

`default_nettype wire

/* rtl/pio_rw_mem.sv */
/*
 * One topic hash-table bank shared by the lookup logic and the PIO bus.
 * Application reads and writes go straight to the RAM every cycle and
 * always win. A PIO request waits in ACCESS for a free cycle, uses the
 * RAM once, then completes the four-phase req/ack handshake.
 * reg_req must only be high when this bank is addressed.
 */
`timescale 1ns/10ps
`default_nettype none

module pio_rw_mem
	import pio_pkg::*, topic_mem_pkg::*;
#(
	parameter int DEPTH_NBITS = 6
) (
	input  logic                   clk,
	input  logic                   rst,

	input  logic                   reg_req,
	input  logic                   reg_wr,
	input  pio_addr_t              reg_addr,
	input  pio_data_t              reg_din,
	output logic                   reg_ack,
	output pio_data_t              reg_rdata,

	input  logic                   app_rd,
	input  logic [DEPTH_NBITS-1:0] app_raddr,
	input  logic                   app_wr,
	input  logic [DEPTH_NBITS-1:0] app_waddr,
	input  bucket_t                app_wdata,
	output logic                   app_ack,
	output bucket_t                app_rdata
);

	typedef enum logic [1:0] {IDLE, ACCESS, ACK, RELEASE} pio_state_t;

	pio_state_t             state;
	logic                   app_busy;
	logic                   pio_go;	// PIO owns the RAM this cycle
	logic [DEPTH_NBITS-1:0] pio_addr;

	logic                   ram_wr;
	logic [DEPTH_NBITS-1:0] ram_waddr;
	bucket_t                ram_din;
	logic [DEPTH_NBITS-1:0] ram_raddr;
	bucket_t                ram_dout;

	assign app_busy = app_rd | app_wr;
	assign pio_go   = (state == ACCESS) & ~app_busy;
	assign pio_addr = reg_addr[DEPTH_NBITS-1:0];	// bank bit dropped

	// application side has priority, PIO only gets idle cycles
	assign ram_wr    = app_wr | (pio_go & reg_wr);
	assign ram_waddr = pio_go ? pio_addr : app_waddr;
	assign ram_din   = pio_go ? bucket_t'(reg_din) : app_wdata;
	assign ram_raddr = pio_go ? pio_addr : app_raddr;

	ram_1r1w #(
		.WIDTH      ($bits(bucket_t)),
		.ADDR_NBITS (DEPTH_NBITS)
	) ram_inst (
		.clk   (clk),
		.wr    (ram_wr),
		.waddr (ram_waddr),
		.din   (ram_din),
		.raddr (ram_raddr),
		.dout  (ram_dout)
	);

	// PIO sequencer
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			reg_ack <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (reg_req) begin
						state <= ACCESS;
					end
				end
				ACCESS: begin
					if (!app_busy) begin
						state <= ACK;	// RAM access happens this cycle
					end
				end
				ACK: begin
					if (!reg_ack) begin
						reg_ack <= 1'b1;
					end else if (!reg_req) begin
						reg_ack <= 1'b0;	// master let go
						state   <= RELEASE;
					end
				end
				RELEASE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// RAM output still holds the PIO read on the first ACK cycle
	always_ff @(posedge clk) begin
		if (state == ACK && !reg_ack && !reg_wr) begin
			reg_rdata <= pio_data_t'(ram_dout);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			app_ack <= 1'b0;
		end else begin
			app_ack <= app_rd;
		end
	end

	assign app_rdata = ram_dout;	// valid while app_ack is high

endmodule

`default_nettype wire

/* rtl/classifier_mem_topic.sv */
/*
 * Topic storage of the message classifier.
 * Holds two hash-table banks (lookup logic plus PIO access), the topic
 * key table and the expiration-time table. After reset a sweep writes
 * zero to every key and expiration-time entry, then raises init_done.
 * PIO bank select is reg_addr[DEPTH_NBITS].
 */
`timescale 1ns/10ps
`default_nettype none

module classifier_mem_topic
	import pio_pkg::*, topic_mem_pkg::*;
#(
	parameter int DEPTH_NBITS       = 6,
	parameter int VALUE_DEPTH_NBITS = 5
) (
	input  logic                         clk,
	input  logic                         rst,

	input  logic                         reg_req,
	input  logic                         reg_wr,
	input  pio_addr_t                    reg_addr,
	input  pio_data_t                    reg_din,
	output logic                         reg_ack,
	output pio_data_t                    reg_rdata,

	input  logic                         ht0_rd,
	input  logic [DEPTH_NBITS-1:0]       ht0_raddr,
	input  logic                         ht0_wr,
	input  logic [DEPTH_NBITS-1:0]       ht0_waddr,
	input  bucket_t                      ht0_wdata,
	output logic                         ht0_ack,
	output bucket_t                      ht0_rdata,

	input  logic                         ht1_rd,
	input  logic [DEPTH_NBITS-1:0]       ht1_raddr,
	input  logic                         ht1_wr,
	input  logic [DEPTH_NBITS-1:0]       ht1_waddr,
	input  bucket_t                      ht1_wdata,
	output logic                         ht1_ack,
	output bucket_t                      ht1_rdata,

	input  logic                         key_rd,
	input  logic [VALUE_DEPTH_NBITS-1:0] key_raddr,
	input  logic                         key_wr,
	input  logic [VALUE_DEPTH_NBITS-1:0] key_waddr,
	input  topic_key_t                   key_wdata,
	output logic                         key_ack,
	output topic_key_t                   key_rdata,

	input  logic                         etime_rd,
	input  logic [VALUE_DEPTH_NBITS-1:0] etime_raddr,
	input  logic                         etime_valid,
	input  logic [VALUE_DEPTH_NBITS-1:0] etime_tid,
	input  exp_time_t                    etime_value,
	output logic                         etime_ack,
	output exp_time_t                    etime_rdata,

	output logic                         init_done
);

	logic                         bank_sel;
	logic                         ht0_reg_ack;
	logic                         ht1_reg_ack;
	pio_data_t                    ht0_reg_rdata;
	pio_data_t                    ht1_reg_rdata;

	logic [VALUE_DEPTH_NBITS:0]   init_cnt;	// msb set once the sweep is done
	logic                         init_active;

	logic                         key_wr_q;
	logic [VALUE_DEPTH_NBITS-1:0] key_waddr_q;
	topic_key_t                   key_wdata_q;
	logic                         etime_wr_q;
	logic [VALUE_DEPTH_NBITS-1:0] etime_waddr_q;
	exp_time_t                    etime_wdata_q;

	assign bank_sel  = reg_addr[DEPTH_NBITS];
	assign reg_ack   = bank_sel ? ht1_reg_ack : ht0_reg_ack;
	assign reg_rdata = bank_sel ? ht1_reg_rdata : ht0_reg_rdata;

	pio_rw_mem #(.DEPTH_NBITS(DEPTH_NBITS)) ht0_inst (
		.clk(clk), .rst(rst),
		.reg_req   (reg_req & ~bank_sel),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_din   (reg_din),
		.reg_ack   (ht0_reg_ack),
		.reg_rdata (ht0_reg_rdata),
		.app_rd    (ht0_rd),
		.app_raddr (ht0_raddr),
		.app_wr    (ht0_wr),
		.app_waddr (ht0_waddr),
		.app_wdata (ht0_wdata),
		.app_ack   (ht0_ack),
		.app_rdata (ht0_rdata)
	);

	pio_rw_mem #(.DEPTH_NBITS(DEPTH_NBITS)) ht1_inst (
		.clk(clk), .rst(rst),
		.reg_req   (reg_req & bank_sel),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_din   (reg_din),
		.reg_ack   (ht1_reg_ack),
		.reg_rdata (ht1_reg_rdata),
		.app_rd    (ht1_rd),
		.app_raddr (ht1_raddr),
		.app_wr    (ht1_wr),
		.app_waddr (ht1_waddr),
		.app_wdata (ht1_wdata),
		.app_ack   (ht1_ack),
		.app_rdata (ht1_rdata)
	);

	// clearing sweep, one entry of each value table per cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			init_cnt <= '0;
		end else if (!init_cnt[VALUE_DEPTH_NBITS]) begin
			init_cnt <= init_cnt + 1'b1;
		end
	end

	assign init_active = ~init_cnt[VALUE_DEPTH_NBITS];
	assign init_done   = init_cnt[VALUE_DEPTH_NBITS];

	// value table writes go through one register stage
	always_ff @(posedge clk) begin
		if (rst) begin
			key_wr_q   <= 1'b0;
			etime_wr_q <= 1'b0;
			key_ack    <= 1'b0;
			etime_ack  <= 1'b0;
		end else begin
			key_wr_q   <= key_wr;
			etime_wr_q <= etime_valid;
			key_ack    <= key_rd;
			etime_ack  <= etime_rd;
		end
	end

	always_ff @(posedge clk) begin
		key_waddr_q   <= key_waddr;
		key_wdata_q   <= key_wdata;
		etime_waddr_q <= etime_tid;
		etime_wdata_q <= etime_value;
	end

	// sweep overrides user writes until init_done
	ram_1r1w #(
		.WIDTH      ($bits(topic_key_t)),
		.ADDR_NBITS (VALUE_DEPTH_NBITS)
	) key_ram_inst (
		.clk   (clk),
		.wr    (init_active | key_wr_q),
		.waddr (init_active ? init_cnt[VALUE_DEPTH_NBITS-1:0] : key_waddr_q),
		.din   (init_active ? topic_key_t'(0) : key_wdata_q),
		.raddr (key_raddr),
		.dout  (key_rdata)
	);

	ram_1r1w #(
		.WIDTH      ($bits(exp_time_t)),
		.ADDR_NBITS (VALUE_DEPTH_NBITS)
	) etime_ram_inst (
		.clk   (clk),
		.wr    (init_active | etime_wr_q),
		.waddr (init_active ? init_cnt[VALUE_DEPTH_NBITS-1:0] : etime_waddr_q),
		.din   (init_active ? exp_time_t'(0) : etime_wdata_q),
		.raddr (etime_raddr),
		.dout  (etime_rdata)
	);

endmodule

`default_nettype wire

/* dv/tb_topic_model.svh */
/*
 * Reference model and bus tasks for the topic storage testbench.
 * Included inside the testbench module, so the tasks drive and sample
 * the DUT signals directly. Every wait here has its own cycle limit.
 */
`ifndef TB_TOPIC_MODEL_SVH
`define TB_TOPIC_MODEL_SVH

	localparam int INIT_TIMEOUT = 100;	// sweep needs VALUE_DEPTH cycles
	localparam int PIO_TIMEOUT  = 500;

	bucket_t    ht_model    [2][HT_DEPTH];
	bit         ht_written  [2][HT_DEPTH];	// buckets are not cleared by reset
	topic_key_t key_model   [VALUE_DEPTH];
	exp_time_t  etime_model [VALUE_DEPTH];

	task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("Errors found");
		$fatal(1, "wait expired");
	endtask

	task automatic wait_init_done();
		int n;
		n = 0;
		while (init_done !== 1'b1) begin
			if (n == INIT_TIMEOUT) fail_timeout("init_done did not rise after reset");
			n++;
			@(negedge clk);
		end
	endtask

	// one four-phase PIO transaction
	task automatic pio_access(input int bank, input logic wr, input logic [DEPTH_NBITS-1:0] idx,
			input pio_data_t data);
		int n;
		@(negedge clk);
		check_equal(64'(reg_ack), 64'(0), "reg_ack low before a new request");
		reg_addr = pio_addr_t'({bank[0], idx});	// bank bit right above the entry bits
		reg_wr   = wr;
		reg_din  = data;
		reg_req  = 1'b1;
		n = 0;
		while (reg_ack !== 1'b1) begin
			if (n == PIO_TIMEOUT) fail_timeout("reg_ack did not rise for a PIO request");
			n++;
			@(negedge clk);
		end
		if (wr) begin
			ht_model[bank][idx]   = data;
			ht_written[bank][idx] = 1'b1;
		end else if (ht_written[bank][idx]) begin
			check_equal(64'(reg_rdata), 64'(ht_model[bank][idx]), "PIO read data");
		end
		reg_req = 1'b0;
		n = 0;
		while (reg_ack !== 1'b0) begin
			if (n == PIO_TIMEOUT) fail_timeout("reg_ack did not fall after reg_req dropped");
			n++;
			@(negedge clk);
		end
	endtask

`endif

/* dv/tb_classifier_mem_topic.sv */
/*
 * Testbench for the topic storage block.
 * Random traffic on the value tables, both hash-table banks and the PIO
 * port, checked against the model arrays in tb_topic_model.svh.
 * Inputs change on the falling clock edge, outputs are sampled there too.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_classifier_mem_topic
	import pio_pkg::*, topic_mem_pkg::*;
();

	localparam int DEPTH_NBITS       = 6;	// DUT defaults
	localparam int VALUE_DEPTH_NBITS = 5;
	localparam int HT_DEPTH          = 2**DEPTH_NBITS;
	localparam int VALUE_DEPTH       = 2**VALUE_DEPTH_NBITS;

	logic                         clk;
	logic                         rst;
	logic                         reg_req;
	logic                         reg_wr;
	logic                         reg_ack;
	pio_addr_t                    reg_addr;
	pio_data_t                    reg_din;
	pio_data_t                    reg_rdata;
	logic                         ht0_rd, ht0_wr, ht0_ack;
	logic                         ht1_rd, ht1_wr, ht1_ack;
	logic [DEPTH_NBITS-1:0]       ht0_raddr, ht0_waddr, ht1_raddr, ht1_waddr;
	bucket_t                      ht0_wdata, ht0_rdata, ht1_wdata, ht1_rdata;
	logic                         key_rd, key_wr, key_ack;
	logic                         etime_rd, etime_valid, etime_ack;
	logic [VALUE_DEPTH_NBITS-1:0] key_raddr, key_waddr, etime_raddr, etime_tid;
	topic_key_t                   key_wdata, key_rdata;
	exp_time_t                    etime_value, etime_rdata;
	logic                         init_done;
	integer                       seed;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	classifier_mem_topic classifier_mem_topic_inst (.*);

`include "tb_topic_model.svh"

	task automatic drive_bank(input int bank, input logic rd, input logic [DEPTH_NBITS-1:0] raddr,
			input logic wr, input logic [DEPTH_NBITS-1:0] waddr, input bucket_t wdata);
		if (bank == 0) begin
			ht0_rd    = rd;
			ht0_raddr = raddr;
			ht0_wr    = wr;
			ht0_waddr = waddr;
			ht0_wdata = wdata;
		end else begin
			ht1_rd    = rd;
			ht1_raddr = raddr;
			ht1_wr    = wr;
			ht1_waddr = waddr;
			ht1_wdata = wdata;
		end
	endtask

	task automatic app_write(input int bank, input logic [DEPTH_NBITS-1:0] idx,
			input bucket_t data);
		@(negedge clk);
		drive_bank(bank, 1'b0, '0, 1'b1, idx, data);
		ht_model[bank][idx]   = data;
		ht_written[bank][idx] = 1'b1;
		@(negedge clk);
		drive_bank(bank, 1'b0, '0, 1'b0, '0, '0);
	endtask

	task automatic app_read_check(input int bank, input logic [DEPTH_NBITS-1:0] idx);
		@(negedge clk);
		check_equal(64'(bank ? ht1_ack : ht0_ack), 64'(0), "hash-table ack before read");
		drive_bank(bank, 1'b1, idx, 1'b0, '0, '0);
		@(negedge clk);
		check_equal(64'(bank ? ht1_ack : ht0_ack), 64'(1), "hash-table ack after read");
		check_equal(64'(bank ? ht1_rdata : ht0_rdata), 64'(ht_model[bank][idx]),
			"hash-table read data");
		drive_bank(bank, 1'b0, '0, 1'b0, '0, '0);
	endtask

	task automatic check_bank(input int bank);
		for (int i = 0; i < HT_DEPTH; i++) begin
			if (ht_written[bank][i]) app_read_check(bank, DEPTH_NBITS'(i));
		end
	endtask

	// back-to-back random reads and writes, entry 0 left alone when skip0 is set
	task automatic run_app_traffic(input int bank, input int cycles, input bit skip0);
		int                     i;
		logic                   rd;
		logic                   wr;
		logic [DEPTH_NBITS-1:0] raddr;
		logic [DEPTH_NBITS-1:0] waddr;
		bucket_t                wdata;
		logic                   prev_rd;
		logic                   prev_known;
		bucket_t                prev_exp;
		prev_rd    = 1'b0;
		prev_known = 1'b0;
		prev_exp   = '0;
		for (i = 0; i <= cycles; i++) begin
			@(negedge clk);
			check_equal(64'(bank ? ht1_ack : ht0_ack), 64'(prev_rd), "hash-table ack timing");
			if (prev_rd && prev_known) begin
				check_equal(64'(bank ? ht1_rdata : ht0_rdata), 64'(prev_exp),
					"hash-table traffic data");
			end
			rd    = (i < cycles) && ($random(seed) % 2 != 0);
			wr    = (i < cycles) && ($random(seed) % 2 != 0);
			raddr = DEPTH_NBITS'($random(seed));
			waddr = DEPTH_NBITS'($random(seed));
			wdata = $random(seed);
			if (skip0 && raddr == '0) raddr = DEPTH_NBITS'(1);
			if (skip0 && waddr == '0) waddr = DEPTH_NBITS'(1);
			prev_known = ht_written[bank][raddr];
			prev_exp   = ht_model[bank][raddr];	// same-cycle write is not seen yet
			if (wr) begin
				ht_model[bank][waddr]   = wdata;
				ht_written[bank][waddr] = 1'b1;
			end
			drive_bank(bank, rd, raddr, wr, waddr, wdata);
			prev_rd = rd;
		end
	endtask

	task automatic value_write(input bit is_key, input logic [VALUE_DEPTH_NBITS-1:0] idx,
			input topic_key_t data);
		@(negedge clk);
		key_wr      = is_key;
		key_waddr   = is_key ? idx : ~idx;	// idle table gets other address and data
		key_wdata   = is_key ? data : ~data;
		etime_valid = !is_key;
		etime_tid   = is_key ? ~idx : idx;
		etime_value = is_key ? ~data[31:0] : data[31:0];
		if (is_key) key_model[idx] = data;
		else etime_model[idx] = data[31:0];
		@(negedge clk);
		key_wr      = 1'b0;
		etime_valid = 1'b0;
	endtask

	task automatic value_read_check(input bit is_key, input logic [VALUE_DEPTH_NBITS-1:0] idx);
		@(negedge clk);
		check_equal(64'(is_key ? key_ack : etime_ack), 64'(0), "value table ack before read");
		key_rd      = is_key;
		key_raddr   = is_key ? idx : ~idx;
		etime_rd    = !is_key;
		etime_raddr = is_key ? ~idx : idx;
		@(negedge clk);
		check_equal(64'(is_key ? key_ack : etime_ack), 64'(1), "value table ack after read");
		if (is_key) check_equal(key_rdata, key_model[idx], "key read data");
		else check_equal(64'(etime_rdata), 64'(etime_model[idx]), "expiration time read data");
		key_rd   = 1'b0;
		etime_rd = 1'b0;
	endtask

	initial begin
		logic [DEPTH_NBITS-1:0] idx;
		bucket_t                data;
		bucket_t                data2;
		seed        = 32'h93c9_a863;
		rst         = 1'b1;
		reg_req     = 1'b0;
		reg_wr      = 1'b0;
		reg_addr    = '0;
		reg_din     = '0;
		key_rd      = 1'b0;
		key_raddr   = '0;
		key_wr      = 1'b0;
		key_waddr   = '0;
		key_wdata   = '0;
		etime_rd    = 1'b0;
		etime_raddr = '0;
		etime_valid = 1'b0;
		etime_tid   = '0;
		etime_value = '0;
		drive_bank(0, 1'b0, '0, 1'b0, '0, '0);
		drive_bank(1, 1'b0, '0, 1'b0, '0, '0);
		for (int i = 0; i < HT_DEPTH; i++) begin
			ht_written[0][i] = 1'b0;
			ht_written[1][i] = 1'b0;
		end
		for (int i = 0; i < VALUE_DEPTH; i++) begin
			key_model[i]   = '0;
			etime_model[i] = '0;
		end

		repeat (3) @(negedge clk);
		check_equal(64'({reg_ack, ht0_ack, ht1_ack, key_ack, etime_ack, init_done}), 64'(0),
			"acks and init_done low in reset");
		rst = 1'b0;
		wait_init_done();

		// sweep cleared both value tables
		for (int i = 0; i < VALUE_DEPTH; i++) begin
			value_read_check(1'b1, VALUE_DEPTH_NBITS'(i));
			value_read_check(1'b0, VALUE_DEPTH_NBITS'(i));
		end

		repeat (40) begin
			value_write(1'b1, VALUE_DEPTH_NBITS'($random(seed)), {$random(seed), $random(seed)});
			value_read_check(1'b1, VALUE_DEPTH_NBITS'($random(seed)));
			value_write(1'b0, VALUE_DEPTH_NBITS'($random(seed)), {$random(seed), $random(seed)});
			value_read_check(1'b0, VALUE_DEPTH_NBITS'($random(seed)));
		end
		for (int i = 0; i < VALUE_DEPTH; i++) begin
			value_read_check(1'b1, VALUE_DEPTH_NBITS'(i));
			value_read_check(1'b0, VALUE_DEPTH_NBITS'(i));
		end

		run_app_traffic(0, 300, 1'b0);
		run_app_traffic(1, 300, 1'b0);
		check_bank(0);
		check_bank(1);	// bank 0 traffic left bank 1 alone

		// PIO against the application port, both directions
		for (int b = 0; b < 2; b++) begin
			repeat (8) begin
				idx = DEPTH_NBITS'($random(seed));
				pio_access(b, 1'b1, idx, $random(seed));
				app_read_check(b, idx);
				idx = DEPTH_NBITS'($random(seed));
				app_write(b, idx, $random(seed));
				pio_access(b, 1'b0, idx, '0);
			end
		end

		// PIO under application back-pressure, entry 0 reserved for PIO
		for (int b = 0; b < 2; b++) begin
			data  = $random(seed);
			data2 = $random(seed);
			pio_access(b, 1'b1, '0, data);
			fork
				run_app_traffic(b, 200, 1'b1);
				begin
					repeat (3) @(negedge clk);
					pio_access(b, 1'b0, '0, '0);
					pio_access(b, 1'b1, '0, data2);
					pio_access(b, 1'b0, '0, '0);
				end
			join
		end
		check_bank(0);
		check_bank(1);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* classifier_mem_topic.f */
+incdir+dv
rtl/pio_pkg.sv
rtl/topic_mem_pkg.sv
rtl/ram_1r1w.sv
rtl/pio_rw_mem.sv
rtl/classifier_mem_topic.sv
dv/tb_classifier_mem_topic.sv

/* Makefile */
# Verilator build for the topic storage block

VERILATOR  ?= verilator
TOP        := tb_classifier_mem_topic
FILELIST   := classifier_mem_topic.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := No errors

LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  := --binary -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

# the run status comes from the log, not from the simulator exit code
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
